// ==== filelist.f ====
shim_pkg.sv
fiu_buffer.sv
tag_pool_ctrl.sv
mdata_store.sv
response_restore.sv
mdata_shim_top.sv
tb_clk_gen.sv
tb_mdata_shim_assertions.sv
tb_mdata_shim.sv

// ==== Bender.yml ====
package:
  name: mdata_shim

sources:
  - files:
      - shim_pkg.sv
      - fiu_buffer.sv
      - tag_pool_ctrl.sv
      - mdata_store.sv
      - response_restore.sv
      - mdata_shim_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_mdata_shim_assertions.sv
      - tb_mdata_shim.sv

// ==== tb_mdata_shim.sv ====
// Testbench for the metadata shim with stimulus table, FIU response model, checker and timeout
module tb_mdata_shim
    import shim_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_rows       = 24;
    localparam int hold_rows      = 15;
    localparam int timeout_cycles = num_rows * 10 + 100;

    // One stimulus row with the values expected back at the AFU
    typedef struct packed {
        logic              chan;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
        mdata_t            mdata;
        logic [2:0]        delay;
        logic [data_w-1:0] exp_rdata;
    } row_t;

    // Row index and the cycle in which it was driven
    typedef struct packed {
        logic [7:0]  row;
        logic [31:0] cyc;
    } track_t;

    // Response parked in the FIU model until its due cycle
    typedef struct packed {
        logic [7:0]        row;
        tag_t              tag;
        logic [31:0]       due;
        logic [addr_w-1:0] addr;
    } pend_t;

    logic   clk;
    logic   rst_n;
    c0_tx_t afu_c0_tx;
    c1_tx_t afu_c1_tx;
    logic   afu_alm_full;
    c0_rx_t afu_c0_rx;
    c1_rx_t afu_c1_rx;
    c0_tx_t fiu_c0_tx;
    c1_tx_t fiu_c1_tx;
    c0_rx_t fiu_c0_rx;
    c1_rx_t fiu_c1_rx;
    logic   fiu_alm_full;

    row_t                rows [num_rows];
    int                  seed = 71;
    int                  cyc = 0;
    logic                hold_rsp;
    // Tags the FIU model currently holds, used to spot a tag handed out twice
    logic [num_tags-1:0] outstanding;
    track_t              c0_req_q[$];
    track_t              c1_req_q[$];
    track_t              c0_rsp_q[$];
    track_t              c1_rsp_q[$];
    pend_t               c0_pend[$];
    pend_t               c1_pend[$];

    tb_clk_gen u_clk_gen (.clk, .rst_n);

    mdata_shim_top uut (.*);

    task automatic stop_on_error();
        $display("test failed");
        $fatal(1, "simulation stopped after the first error");
    endtask

    task automatic compare_value(input string name, input logic [data_w-1:0] got,
                                 input logic [data_w-1:0] exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    // Reads are two of every three rows, delays come from the seeded generator
    task automatic build_table();
        logic [addr_w-1:0] a;
        for (int i = 0; i < num_rows; i++)
        begin
            a                 = 32'h4000_0000 | (i << 6);
            rows[i].chan      = ((i % 3) == 2);
            rows[i].addr      = a;
            rows[i].data      = {a ^ 32'h5a5a_0000, ~a};
            rows[i].mdata     = 16'hc000 + mdata_t'(i * 16'h0107);
            rows[i].delay     = 3'($unsigned($random(seed)) % 7);
            rows[i].exp_rdata = {~a, ~a};
        end
    endtask

    // Called 1 ns after a rising edge, returns 1 ns after the next one
    task automatic issue_row(input int r);
        while (afu_alm_full)
        begin
            @(posedge clk);
            #1;
        end
        if (rows[r].chan)
        begin
            afu_c1_tx = '{valid: 1'b1, addr: rows[r].addr, data: rows[r].data,
                          mdata: rows[r].mdata};
            c1_req_q.push_back('{row: 8'(r), cyc: 32'(cyc)});
        end
        else
        begin
            afu_c0_tx = '{valid: 1'b1, addr: rows[r].addr, mdata: rows[r].mdata};
            c0_req_q.push_back('{row: 8'(r), cyc: 32'(cyc)});
        end
        @(posedge clk);
        #1;
        afu_c0_tx.valid = 1'b0;
        afu_c1_tx.valid = 1'b0;
    endtask

    // Waits until every request has been answered and seen at the AFU
    task automatic wait_drain();
        do
        begin
            @(negedge clk);
            #1;
        end while (c0_req_q.size() + c1_req_q.size() + c0_pend.size() + c1_pend.size()
                   + c0_rsp_q.size() + c1_rsp_q.size() != 0);
        // Two edges more so the freed tags are back in the pool
        repeat (2)
        begin
            @(posedge clk);
        end
        #1;
    endtask

    // Oldest parked response whose delay has run out, or -1
    function automatic int first_due(input pend_t q[$], input int now);
        int idx;
        idx = -1;
        for (int i = q.size() - 1; i >= 0; i--)
        begin
            if (int'(q[i].due) <= now)
            begin
                idx = i;
            end
        end
        return idx;
    endfunction

    // FIU model, at most one response per channel and cycle
    task automatic send_responses();
        pend_t p;
        int    idx;
        fiu_c0_rx = '0;
        fiu_c1_rx = '0;
        if (!hold_rsp)
        begin
            idx = first_due(c0_pend, cyc);
            if (idx >= 0)
            begin
                p = c0_pend[idx];
                c0_pend.delete(idx);
                // Read data is the inverted address in both halves
                fiu_c0_rx.valid = 1'b1;
                fiu_c0_rx.data  = {~p.addr, ~p.addr};
                fiu_c0_rx.mdata = mdata_t'(p.tag);
                outstanding[p.tag] = 1'b0;
                c0_rsp_q.push_back('{row: p.row, cyc: 32'(cyc)});
            end
            idx = first_due(c1_pend, cyc);
            if (idx >= 0)
            begin
                p = c1_pend[idx];
                c1_pend.delete(idx);
                fiu_c1_rx.valid = 1'b1;
                fiu_c1_rx.mdata = mdata_t'(p.tag);
                outstanding[p.tag] = 1'b0;
                c1_rsp_q.push_back('{row: p.row, cyc: 32'(cyc)});
            end
        end
    endtask

    // A request seen on the FIU side is checked and parked with its row delay
    task automatic accept_request(input logic chan, input logic valid,
                                  input logic [addr_w-1:0] addr,
                                  input logic [data_w-1:0] data, input mdata_t mdata);
        track_t t;
        pend_t  p;
        tag_t   tag;
        logic   exp_v;
        if (chan)
        begin
            exp_v = (c1_req_q.size() != 0) && (int'(c1_req_q[0].cyc) + 1 == cyc);
        end
        else
        begin
            exp_v = (c0_req_q.size() != 0) && (int'(c0_req_q[0].cyc) + 1 == cyc);
        end
        compare_value($sformatf("fiu_c%0d_tx.valid", chan), valid, exp_v);
        if (exp_v)
        begin
            if (chan)
            begin
                t = c1_req_q.pop_front();
                compare_value("fiu_c1_tx.data", data, rows[t.row].data);
            end
            else
            begin
                t = c0_req_q.pop_front();
            end
            compare_value($sformatf("fiu_c%0d_tx.addr", chan), addr, rows[t.row].addr);
            compare_value($sformatf("fiu_c%0d_tx.mdata upper bits", chan), mdata >> tag_w, 0);
            tag = mdata[tag_w-1:0];
            compare_value($sformatf("outstanding flag of tag %0d", tag), outstanding[tag], 0);
            outstanding[tag] = 1'b1;
            p = '{row: t.row, tag: tag, due: 32'(cyc + 1) + rows[t.row].delay, addr: addr};
            if (chan)
            begin
                c1_pend.push_back(p);
            end
            else
            begin
                c0_pend.push_back(p);
            end
        end
    endtask

    // A response at the AFU must follow its FIU response by one cycle
    task automatic accept_response(input logic chan, input logic valid,
                                   input logic [data_w-1:0] data, input mdata_t mdata);
        track_t t;
        logic   exp_v;
        if (chan)
        begin
            exp_v = (c1_rsp_q.size() != 0) && (int'(c1_rsp_q[0].cyc) + 1 == cyc);
        end
        else
        begin
            exp_v = (c0_rsp_q.size() != 0) && (int'(c0_rsp_q[0].cyc) + 1 == cyc);
        end
        compare_value($sformatf("afu_c%0d_rx.valid", chan), valid, exp_v);
        if (exp_v)
        begin
            if (chan)
            begin
                t = c1_rsp_q.pop_front();
            end
            else
            begin
                t = c0_rsp_q.pop_front();
                compare_value("afu_c0_rx.data", data, rows[t.row].exp_rdata);
            end
            compare_value($sformatf("afu_c%0d_rx.mdata", chan), mdata, rows[t.row].mdata);
        end
    endtask

    // Responses go out after the rising edge, outputs are sampled on the falling edge
    initial
    begin
        fiu_c0_rx   = '0;
        fiu_c1_rx   = '0;
        outstanding = '0;
        forever
        begin
            @(posedge clk);
            #1;
            send_responses();
            @(negedge clk);
            accept_request(1'b0, fiu_c0_tx.valid, fiu_c0_tx.addr, '0, fiu_c0_tx.mdata);
            accept_request(1'b1, fiu_c1_tx.valid, fiu_c1_tx.addr, fiu_c1_tx.data,
                           fiu_c1_tx.mdata);
            accept_response(1'b0, afu_c0_rx.valid, afu_c0_rx.data, afu_c0_rx.mdata);
            accept_response(1'b1, afu_c1_rx.valid, '0, afu_c1_rx.mdata);
        end
    end

    // A failed assertion in the bound checker ends the run
    always @(negedge clk)
    begin
        if (uut.u_assertions.fail_count != 0)
        begin
            $display("An assertion in the bound checker failed, see the error above");
            stop_on_error();
        end
    end

    always @(posedge clk)
    begin
        cyc <= cyc + 1;
        if (cyc >= timeout_cycles)
        begin
            $display("TIMEOUT: the run did not finish within %0d cycles", timeout_cycles);
            stop_on_error();
        end
    end

    initial
    begin
        afu_c0_tx    = '0;
        afu_c1_tx    = '0;
        fiu_alm_full = 1'b0;
        hold_rsp     = 1'b0;
        build_table();
        @(posedge rst_n);
        @(posedge clk);
        #1;

        // Random delays make responses return out of order
        for (int r = 0; r < num_rows; r++)
        begin
            issue_row(r);
        end
        wait_drain();

        // FIU almost-full shows up at the AFU one cycle later
        compare_value("afu_alm_full", afu_alm_full, 1'b0);
        fiu_alm_full = 1'b1;
        #1;
        compare_value("afu_alm_full", afu_alm_full, 1'b0);
        @(posedge clk);
        #1;
        compare_value("afu_alm_full", afu_alm_full, 1'b1);
        fiu_alm_full = 1'b0;
        @(posedge clk);
        #1;
        compare_value("afu_alm_full", afu_alm_full, 1'b0);

        // With every response held, 15 requests leave a single free tag
        hold_rsp = 1'b1;
        for (int r = 0; r < hold_rows; r++)
        begin
            compare_value("afu_alm_full", afu_alm_full, 1'b0);
            issue_row(r);
        end
        compare_value("afu_alm_full", afu_alm_full, 1'b1);
        repeat (3)
        begin
            @(posedge clk);
        end
        #1;
        compare_value("afu_alm_full", afu_alm_full, 1'b1);
        @(negedge clk);
        hold_rsp = 1'b0;
        wait_drain();
        compare_value("afu_alm_full", afu_alm_full, 1'b0);

        if (uut.u_assertions.fail_count == 0)
        begin
            $display("test passed");
            $finish;
        end
        else
        begin
            $display("An assertion in the bound checker failed near the end of the run");
            stop_on_error();
        end
    end

endmodule

// ==== tb_mdata_shim_assertions.sv ====
// Latency, reset and flow control assertions for the shim top level, with their bind
module tb_mdata_shim_assertions import shim_pkg::*;
(
    input logic   clk,
    input logic   rst_n,
    input c0_tx_t afu_c0_tx,
    input c1_tx_t afu_c1_tx,
    input logic   afu_alm_full,
    input c0_rx_t afu_c0_rx,
    input c1_rx_t afu_c1_rx,
    input c0_tx_t fiu_c0_tx,
    input c1_tx_t fiu_c1_tx,
    input c0_rx_t fiu_c0_rx,
    input c1_rx_t fiu_c1_rx
);

    timeunit 1ns;
    timeprecision 100ps;

    // Number of assertion failures so far, watched by the testbench
    int fail_count = 0;

    // Requests cross the outbound register in exactly one cycle
    a_c0_req_latency: assert property (@(posedge clk) disable iff (!rst_n)
        afu_c0_tx.valid |=> fiu_c0_tx.valid && fiu_c0_tx.addr == $past(afu_c0_tx.addr))
        else
        begin
            fail_count++;
            $error("c0 request did not reach the FIU one cycle later");
        end

    a_c1_req_latency: assert property (@(posedge clk) disable iff (!rst_n)
        afu_c1_tx.valid |=> fiu_c1_tx.valid && fiu_c1_tx.data == $past(afu_c1_tx.data))
        else
        begin
            fail_count++;
            $error("c1 request did not reach the FIU one cycle later");
        end

    // Responses come back to the AFU one cycle after the FIU strobe
    a_c0_rsp_latency: assert property (@(posedge clk) disable iff (!rst_n)
        fiu_c0_rx.valid |=> afu_c0_rx.valid && afu_c0_rx.data == $past(fiu_c0_rx.data))
        else
        begin
            fail_count++;
            $error("c0 response did not reach the AFU one cycle later");
        end

    a_c1_rsp_latency: assert property (@(posedge clk) disable iff (!rst_n)
        fiu_c1_rx.valid |=> afu_c1_rx.valid)
        else
        begin
            fail_count++;
            $error("c1 acknowledge did not reach the AFU one cycle later");
        end

    // Checked on the falling edge so the first reset edge has already acted
    a_reset_quiet: assert property (@(negedge clk)
        !rst_n |-> !fiu_c0_tx.valid && !fiu_c1_tx.valid && !afu_c0_rx.valid
                   && !afu_c1_rx.valid && !afu_alm_full)
        else
        begin
            fail_count++;
            $error("valid or almost-full high during reset");
        end

    // The AFU must hold off while almost-full is raised
    a_no_req_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        afu_alm_full |-> !afu_c0_tx.valid && !afu_c1_tx.valid)
        else
        begin
            fail_count++;
            $error("AFU request issued while almost-full was high");
        end

endmodule

bind mdata_shim_top tb_mdata_shim_assertions u_assertions (.*);

// ==== tb_clk_gen.sv ====
// Testbench clock source and power-on reset generator
module tb_clk_gen
(
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    // 10 ns period
    localparam real half_period  = 5.0;
    localparam int  reset_cycles = 3;

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #half_period clk = ~clk;
        end
    end

    // Reset is released just after the third rising edge
    initial
    begin
        rst_n = 1'b0;
        repeat (reset_cycles)
        begin
            @(posedge clk);
        end
        #1 rst_n = 1'b1;
    end

endmodule

// ==== mdata_shim_top.sv ====
// Top level of the metadata shim joining tag control, FIU buffer, metadata store and restore
module mdata_shim_top import shim_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    // AFU side
    input  c0_tx_t afu_c0_tx,
    input  c1_tx_t afu_c1_tx,
    output logic   afu_alm_full,
    output c0_rx_t afu_c0_rx,
    output c1_rx_t afu_c1_rx,
    // FIU side
    output c0_tx_t fiu_c0_tx,
    output c1_tx_t fiu_c1_tx,
    input  c0_rx_t fiu_c0_rx,
    input  c1_rx_t fiu_c1_rx,
    input  logic   fiu_alm_full
);

    // Rewritten requests between the pool and the buffer
    c0_tx_t buf_c0_tx;
    c1_tx_t buf_c1_tx;
    logic   buf_alm_full;

    // Store write ports
    logic   wr_c0_en;
    logic   wr_c1_en;
    tag_t   wr_c0_tag;
    tag_t   wr_c1_tag;
    mdata_t wr_c0_mdata;
    mdata_t wr_c1_mdata;

    // Response path
    c0_rx_t raw_c0_rx;
    c1_rx_t raw_c1_rx;
    c0_rx_t buf_c0_rx;
    c1_rx_t buf_c1_rx;
    tag_t   rd_c0_tag;
    tag_t   rd_c1_tag;
    mdata_t rd_c0_mdata;
    mdata_t rd_c1_mdata;

    // Tag release
    logic   free_c0_en;
    logic   free_c1_en;
    tag_t   free_c0_tag;
    tag_t   free_c1_tag;

    // The lookup uses the tag bits of the raw response
    assign rd_c0_tag = raw_c0_rx.mdata[tag_w-1:0];
    assign rd_c1_tag = raw_c1_rx.mdata[tag_w-1:0];

    tag_pool_ctrl u_tag_pool_ctrl (
        .clk, .rst_n, .afu_c0_tx, .afu_c1_tx, .buf_c0_tx, .buf_c1_tx,
        .wr_c0_en, .wr_c1_en, .wr_c0_tag, .wr_c1_tag, .wr_c0_mdata, .wr_c1_mdata,
        .free_c0_en, .free_c1_en, .free_c0_tag, .free_c1_tag,
        .buf_alm_full, .afu_alm_full
    );

    fiu_buffer u_fiu_buffer (
        .clk, .rst_n, .buf_c0_tx, .buf_c1_tx, .fiu_c0_tx, .fiu_c1_tx,
        .fiu_alm_full, .buf_alm_full, .fiu_c0_rx, .fiu_c1_rx,
        .raw_c0_rx, .raw_c1_rx, .buf_c0_rx, .buf_c1_rx
    );

    mdata_store u_mdata_store (
        .clk, .wr_c0_en, .wr_c0_tag, .wr_c0_mdata, .wr_c1_en, .wr_c1_tag, .wr_c1_mdata,
        .rd_c0_tag, .rd_c1_tag, .rd_c0_mdata, .rd_c1_mdata
    );

    response_restore u_response_restore (
        .buf_c0_rx, .buf_c1_rx, .rd_c0_mdata, .rd_c1_mdata, .afu_c0_rx, .afu_c1_rx,
        .free_c0_en, .free_c0_tag, .free_c1_en, .free_c1_tag
    );

endmodule

// ==== response_restore.sv ====
// Response merge that restores AFU metadata and reports the returned tags for release
module response_restore import shim_pkg::*;
(
    // Buffered responses still carrying tags
    input  c0_rx_t buf_c0_rx,
    input  c1_rx_t buf_c1_rx,
    // Metadata looked up one cycle earlier from the raw responses
    input  mdata_t rd_c0_mdata,
    input  mdata_t rd_c1_mdata,
    // Responses as the AFU expects them
    output c0_rx_t afu_c0_rx,
    output c1_rx_t afu_c1_rx,
    // Tag release toward the pool
    output logic   free_c0_en,
    output tag_t   free_c0_tag,
    output logic   free_c1_en,
    output tag_t   free_c1_tag
);

    // Read path
    always_comb
    begin
        afu_c0_rx = buf_c0_rx;
        // Metadata is only swapped on a valid beat, idle cycles pass unchanged
        if (buf_c0_rx.valid)
        begin
            afu_c0_rx.mdata = rd_c0_mdata;
        end
        free_c0_en  = buf_c0_rx.valid;
        free_c0_tag = buf_c0_rx.mdata[tag_w-1:0];
    end

    // Write acknowledge path
    always_comb
    begin
        afu_c1_rx = buf_c1_rx;
        if (buf_c1_rx.valid)
        begin
            afu_c1_rx.mdata = rd_c1_mdata;
        end
        free_c1_en  = buf_c1_rx.valid;
        free_c1_tag = buf_c1_rx.mdata[tag_w-1:0];
    end

endmodule

// ==== mdata_store.sv ====
// Metadata RAM indexed by tag with two write ports and two registered read ports
module mdata_store import shim_pkg::*;
(
    input  logic   clk,
    // Write ports from tag allocation
    input  logic   wr_c0_en,
    input  tag_t   wr_c0_tag,
    input  mdata_t wr_c0_mdata,
    input  logic   wr_c1_en,
    input  tag_t   wr_c1_tag,
    input  mdata_t wr_c1_mdata,
    // Read ports addressed by the tags of raw FIU responses
    input  tag_t   rd_c0_tag,
    input  tag_t   rd_c1_tag,
    output mdata_t rd_c0_mdata,
    output mdata_t rd_c1_mdata
);

    // One AFU metadata word per tag
    mdata_t mem [num_tags];

    // The allocator never hands the same tag to both channels in one cycle,
    // so the two write ports never hit the same entry
    always_ff @(posedge clk)
    begin
        if (wr_c0_en)
        begin
            mem[wr_c0_tag] <= wr_c0_mdata;
        end
        if (wr_c1_en)
        begin
            mem[wr_c1_tag] <= wr_c1_mdata;
        end
    end

    // Registered reads behave like a block RAM with one cycle of latency
    // A tag is written at least one cycle before its response can come back
    always_ff @(posedge clk)
    begin
        rd_c0_mdata <= mem[rd_c0_tag];
        rd_c1_mdata <= mem[rd_c1_tag];
    end

endmodule

// ==== tag_pool_ctrl.sv ====
// Tag pool control with busy bitmap, request metadata rewrite, tag release and almost-full
module tag_pool_ctrl import shim_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    // Requests from the AFU and their rewritten form
    input  c0_tx_t afu_c0_tx,
    input  c1_tx_t afu_c1_tx,
    output c0_tx_t buf_c0_tx,
    output c1_tx_t buf_c1_tx,
    // Metadata store write ports
    output logic   wr_c0_en,
    output logic   wr_c1_en,
    output tag_t   wr_c0_tag,
    output tag_t   wr_c1_tag,
    output mdata_t wr_c0_mdata,
    output mdata_t wr_c1_mdata,
    // Tags released by returning responses
    input  logic   free_c0_en,
    input  logic   free_c1_en,
    input  tag_t   free_c0_tag,
    input  tag_t   free_c1_tag,
    // Flow control
    input  logic   buf_alm_full,
    output logic   afu_alm_full
);

    // One bit per tag, set while the tag is outstanding
    logic [num_tags-1:0] busy_q;
    logic [num_tags-1:0] busy_d;
    // Busy map with the c0 candidate also marked, used to pick the c1 tag
    logic [num_tags-1:0] busy_after_c0;
    logic [cnt_w-1:0]    free_cnt_q;
    tag_t                c0_tag;
    tag_t                c1_tag;

    // Priority search from the top down so the lowest free index wins
    function automatic tag_t lowest_free(input logic [num_tags-1:0] busy);
        tag_t tag;
        tag = '0;
        for (int i = num_tags - 1; i >= 0; i--)
        begin
            if (!busy[i])
            begin
                tag = tag_t'(i);
            end
        end
        return tag;
    endfunction

    // The two candidates are computed every cycle whether or not a request is present
    always_comb
    begin
        c0_tag                = lowest_free(busy_q);
        busy_after_c0         = busy_q;
        busy_after_c0[c0_tag] = 1'b1;
        c1_tag                = lowest_free(busy_after_c0);
    end

    // Requests go out with the tag in place of the AFU metadata
    always_comb
    begin
        buf_c0_tx       = afu_c0_tx;
        buf_c0_tx.mdata = tag_to_mdata(c0_tag);
        buf_c1_tx       = afu_c1_tx;
        buf_c1_tx.mdata = tag_to_mdata(c1_tag);
    end

    // The original metadata is parked at the allocated tag
    assign wr_c0_en    = afu_c0_tx.valid;
    assign wr_c1_en    = afu_c1_tx.valid;
    assign wr_c0_tag   = c0_tag;
    assign wr_c1_tag   = c1_tag;
    assign wr_c0_mdata = afu_c0_tx.mdata;
    assign wr_c1_mdata = afu_c1_tx.mdata;

    // Allocated tags are free and freed tags are busy, so the updates never collide
    always_comb
    begin
        busy_d = busy_q;
        if (afu_c0_tx.valid)
        begin
            busy_d[c0_tag] = 1'b1;
        end
        if (afu_c1_tx.valid)
        begin
            busy_d[c1_tag] = 1'b1;
        end
        if (free_c0_en)
        begin
            busy_d[free_c0_tag] = 1'b0;
        end
        if (free_c1_en)
        begin
            busy_d[free_c1_tag] = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy_q     <= '0;
            free_cnt_q <= cnt_w'(num_tags);
        end
        else
        begin
            busy_q     <= busy_d;
            free_cnt_q <= free_cnt_q
                          - cnt_w'(afu_c0_tx.valid) - cnt_w'(afu_c1_tx.valid)
                          + cnt_w'(free_c0_en) + cnt_w'(free_c1_en);
        end
    end

    // Hold the AFU off while the FIU is full or a two-request cycle could run dry
    assign afu_alm_full = buf_alm_full || (free_cnt_q < cnt_w'(alm_full_thresh));

endmodule

// ==== fiu_buffer.sv ====
// FIU-side interposer with a one-cycle response stage and an optional request stage
module fiu_buffer import shim_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    // Requests from the shim logic heading to the FIU
    input  c0_tx_t buf_c0_tx,
    input  c1_tx_t buf_c1_tx,
    output c0_tx_t fiu_c0_tx,
    output c1_tx_t fiu_c1_tx,
    // Almost-full from the FIU and its copy for the shim logic
    input  logic   fiu_alm_full,
    output logic   buf_alm_full,
    // Responses from the FIU, raw for the RAM lookup and buffered for the merge
    input  c0_rx_t fiu_c0_rx,
    input  c1_rx_t fiu_c1_rx,
    output c0_rx_t raw_c0_rx,
    output c1_rx_t raw_c1_rx,
    output c0_rx_t buf_c0_rx,
    output c1_rx_t buf_c1_rx
);

    // Response payload registers, their valid bits are held separately under reset
    c0_rx_t c0_rx_q;
    c1_rx_t c1_rx_q;
    logic   c0_rx_valid_q;
    logic   c1_rx_valid_q;

    // The raw responses start the metadata RAM read in their arrival cycle
    assign raw_c0_rx = fiu_c0_rx;
    assign raw_c1_rx = fiu_c1_rx;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            c0_rx_valid_q <= 1'b0;
            c1_rx_valid_q <= 1'b0;
        end
        else
        begin
            c0_rx_valid_q <= fiu_c0_rx.valid;
            c1_rx_valid_q <= fiu_c1_rx.valid;
        end
    end

    always_ff @(posedge clk)
    begin
        c0_rx_q <= fiu_c0_rx;
        c1_rx_q <= fiu_c1_rx;
    end

    // Payload from the data register, valid from the reset register
    always_comb
    begin
        buf_c0_rx       = c0_rx_q;
        buf_c0_rx.valid = c0_rx_valid_q;
        buf_c1_rx       = c1_rx_q;
        buf_c1_rx.valid = c1_rx_valid_q;
    end

    generate
        if (register_outbound)
        begin : g_outbound_reg
            // One register stage on every signal leaving toward the FIU
            c0_tx_t c0_tx_q;
            c1_tx_t c1_tx_q;
            logic   c0_tx_valid_q;
            logic   c1_tx_valid_q;

            always_ff @(posedge clk or negedge rst_n)
            begin
                if (!rst_n)
                begin
                    c0_tx_valid_q <= 1'b0;
                    c1_tx_valid_q <= 1'b0;
                    buf_alm_full  <= 1'b0;
                end
                else
                begin
                    c0_tx_valid_q <= buf_c0_tx.valid;
                    c1_tx_valid_q <= buf_c1_tx.valid;
                    buf_alm_full  <= fiu_alm_full;
                end
            end

            always_ff @(posedge clk)
            begin
                c0_tx_q <= buf_c0_tx;
                c1_tx_q <= buf_c1_tx;
            end

            always_comb
            begin
                fiu_c0_tx       = c0_tx_q;
                fiu_c0_tx.valid = c0_tx_valid_q;
                fiu_c1_tx       = c1_tx_q;
                fiu_c1_tx.valid = c1_tx_valid_q;
            end
        end
        else
        begin : g_outbound_wire
            // Requests and almost-full cross without delay
            assign fiu_c0_tx    = buf_c0_tx;
            assign fiu_c1_tx    = buf_c1_tx;
            assign buf_alm_full = fiu_alm_full;
        end
    endgenerate

endmodule

// ==== shim_pkg.sv ====
// Shared widths, tag pool sizing, outbound register switch and channel structs of the shim
package shim_pkg;

    // Widths of the memory channels as seen by the AFU
    localparam int addr_w  = 32;
    localparam int data_w  = 64;
    localparam int mdata_w = 16;

    // The shared tag pool covers both request channels
    localparam int num_tags = 16;
    localparam int tag_w    = $clog2(num_tags);

    // Free tag counter has to hold the value num_tags itself
    localparam int cnt_w = $clog2(num_tags + 1);

    // Two requests can be issued per cycle, so this many free tags must remain
    localparam int alm_full_thresh = 2;

    // Set to 1 to put a register stage on requests and almost-full toward the FIU
    localparam bit register_outbound = 1'b1;

    typedef logic [tag_w-1:0]   tag_t;
    typedef logic [mdata_w-1:0] mdata_t;

    // Read request, 49 bits
    typedef struct packed {
        logic              valid;
        logic [addr_w-1:0] addr;
        mdata_t            mdata;
    } c0_tx_t;

    // Write request, 113 bits
    typedef struct packed {
        logic              valid;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
        mdata_t            mdata;
    } c1_tx_t;

    // Read response, 81 bits
    typedef struct packed {
        logic              valid;
        logic [data_w-1:0] data;
        mdata_t            mdata;
    } c0_rx_t;

    // Write acknowledge, 17 bits
    typedef struct packed {
        logic   valid;
        mdata_t mdata;
    } c1_rx_t;

    // On the FIU side only the low tag_w bits of mdata are meaningful
    function automatic mdata_t tag_to_mdata(input tag_t tag);
        mdata_t m;
        m = '0;
        m[tag_w-1:0] = tag;
        return m;
    endfunction

endpackage
